// File: design/dcache_pkg.sv
// Data cache definitions
package dcache_pkg;

	// Widths of the data path
	localparam int ADDR_W = 14;
	localparam int WORD_W = 32;
	localparam int TAG_W = ADDR_W - 2;

	// Cache geometry
	localparam int CACHE_LINES = 4;
	localparam int AGE_W = $clog2(CACHE_LINES);

	// Backing RAM, indexed by the low word address bits
	localparam int MEM_WORDS = 1024;
	localparam int MEM_IDX_W = $clog2(MEM_WORDS);

	// Bit positions inside the size and sign mask
	localparam int MASK_HALF = 1;
	localparam int MASK_WORD = 2;
	localparam int MASK_SIGNED = 3;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [1:0] byte_off_t;
	typedef logic [3:0] mask_t;
	typedef logic [AGE_W-1:0] age_t;
	typedef logic [CACHE_LINES-1:0] line_sel_t;
	typedef logic [MEM_IDX_W-1:0] mem_idx_t;

	// Memory mapped LED register
	localparam addr_t LED_ADDR = 14'h2000;

	typedef enum logic [1:0] {
		IN_CACHE,
		ACCESS_MEMORY,
		UPDATE_CACHE
	} cache_state_t;

endpackage

// File: design/cache_line.sv
// Single cache line
`timescale 1ns/1ps

module cache_line (
	input  logic               clk,
	input  logic               rst_n,
	input  dcache_pkg::tag_t   cur_tag,
	input  dcache_pkg::word_t  line_wdata,
	input  logic               line_write,
	input  logic               access,
	input  dcache_pkg::age_t   accessed_age,
	input  dcache_pkg::age_t   reset_age,
	output dcache_pkg::word_t  data,
	output dcache_pkg::tag_t   tag,
	output logic               valid,
	output dcache_pkg::age_t   age,
	output logic               match
);

	logic selected;

	assign match = valid && (tag == cur_tag);

	// Ages form a permutation, so only the accessed line carries its age
	assign selected = (age == accessed_age);

	// Word and tag carry no reset, only the valid bit and the age
	always_ff @(posedge clk) begin
		if (selected && access && line_write) begin
			data <= line_wdata;
			tag <= cur_tag;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= 1'b0;
			age <= reset_age;
		end else if (access) begin
			if (selected) begin
				age <= dcache_pkg::age_t'(dcache_pkg::CACHE_LINES - 1);
				if (line_write)
					valid <= 1'b1;
			end else if (age > accessed_age) begin
				age <= age - dcache_pkg::age_t'(1);
			end
		end
	end

endmodule

// File: design/line_array.sv
// Cache line array and LRU selection
`timescale 1ns/1ps

module line_array (
	input  logic               clk,
	input  logic               rst_n,
	input  dcache_pkg::addr_t  cur_addr,
	input  dcache_pkg::word_t  line_wdata,
	input  logic               line_write,
	input  logic               access,
	output logic               hit,
	output dcache_pkg::word_t  sel_word,
	output dcache_pkg::tag_t   sel_tag,
	output logic               sel_valid
);

	dcache_pkg::word_t line_data [dcache_pkg::CACHE_LINES];
	dcache_pkg::tag_t line_tag [dcache_pkg::CACHE_LINES];
	dcache_pkg::age_t line_age [dcache_pkg::CACHE_LINES];
	dcache_pkg::line_sel_t line_valid;
	dcache_pkg::line_sel_t line_match;
	dcache_pkg::line_sel_t line_old;
	dcache_pkg::line_sel_t line_sel;
	dcache_pkg::age_t sel_age;

	generate
		for (genvar i = 0; i < dcache_pkg::CACHE_LINES; i++) begin : g_line
			cache_line i_line (
				.clk          (clk),
				.rst_n        (rst_n),
				.cur_tag      (cur_addr[dcache_pkg::ADDR_W-1:2]),
				.line_wdata   (line_wdata),
				.line_write   (line_write),
				.access       (access),
				.accessed_age (sel_age),
				.reset_age    (dcache_pkg::age_t'(i)),
				.data         (line_data[i]),
				.tag          (line_tag[i]),
				.valid        (line_valid[i]),
				.age          (line_age[i]),
				.match        (line_match[i])
			);

			assign line_old[i] = (line_age[i] == '0);
		end
	endgenerate

	assign hit = |line_match;

	// On a miss the oldest line is the victim
	assign line_sel = hit ? line_match : line_old;

	// AND-OR selection of the accessed line
	always_comb begin
		sel_word = '0;
		sel_tag = '0;
		sel_valid = 1'b0;
		sel_age = '0;
		for (int i = 0; i < dcache_pkg::CACHE_LINES; i++) begin
			sel_word |= line_data[i] & {dcache_pkg::WORD_W{line_sel[i]}};
			sel_tag |= line_tag[i] & {dcache_pkg::TAG_W{line_sel[i]}};
			sel_valid |= line_valid[i] & line_sel[i];
			sel_age |= line_age[i] & {dcache_pkg::AGE_W{line_sel[i]}};
		end
	end

endmodule

// File: design/store_merge.sv
// Store data merge
`timescale 1ns/1ps

module store_merge (
	input  dcache_pkg::word_t      source_word,
	input  dcache_pkg::word_t      store_data,
	input  dcache_pkg::byte_off_t  offset,
	input  dcache_pkg::mask_t      mask,
	output dcache_pkg::word_t      merged_word
);

	// Start from the stored word and overwrite the addressed lanes
	always_comb begin
		merged_word = source_word;
		if (mask[dcache_pkg::MASK_WORD]) begin
			merged_word = store_data;
		end else if (mask[dcache_pkg::MASK_HALF]) begin
			if (offset[1])
				merged_word[31:16] = store_data[15:0];
			else
				merged_word[15:0] = store_data[15:0];
		end else begin
			// Byte store, the lane follows the byte offset
			merged_word[{offset, 3'b000} +: 8] = store_data[7:0];
		end
	end

endmodule

// File: design/load_align.sv
// Load data alignment
`timescale 1ns/1ps

module load_align (
	input  dcache_pkg::word_t      source_word,
	input  dcache_pkg::byte_off_t  offset,
	input  dcache_pkg::mask_t      mask,
	output dcache_pkg::word_t      load_word
);

	logic [7:0] lane_byte;
	logic [15:0] lane_half;
	logic sign_fill;

	assign lane_byte = source_word[{offset, 3'b000} +: 8];
	assign lane_half = offset[1] ? source_word[31:16] : source_word[15:0];

	always_comb begin
		sign_fill = 1'b0;
		if (mask[dcache_pkg::MASK_WORD]) begin
			load_word = source_word;
		end else if (mask[dcache_pkg::MASK_HALF]) begin
			sign_fill = mask[dcache_pkg::MASK_SIGNED] & lane_half[15];
			load_word = {{16{sign_fill}}, lane_half};
		end else begin
			// Bytes extend from bit 7 of the lane when signed
			sign_fill = mask[dcache_pkg::MASK_SIGNED] & lane_byte[7];
			load_word = {{24{sign_fill}}, lane_byte};
		end
	end

endmodule

// File: design/miss_control.sv
// Cache miss controller
`timescale 1ns/1ps

module miss_control (
	input  logic               clk,
	input  logic               rst_n,
	input  dcache_pkg::addr_t  addr,
	input  dcache_pkg::word_t  write_data,
	input  logic               memwrite,
	input  logic               memread,
	input  dcache_pkg::mask_t  sign_mask,
	input  logic               hit,
	input  dcache_pkg::word_t  sel_word,
	input  dcache_pkg::tag_t   sel_tag,
	input  logic               sel_valid,
	input  dcache_pkg::word_t  load_word,
	input  dcache_pkg::word_t  merged_word,
	output dcache_pkg::addr_t  cur_addr,
	output dcache_pkg::word_t  cur_wdata,
	output dcache_pkg::mask_t  cur_mask,
	output dcache_pkg::word_t  source_word,
	output logic               access,
	output logic               line_write,
	output dcache_pkg::word_t  line_wdata,
	output dcache_pkg::word_t  read_data,
	output logic [7:0]         led,
	output logic               clk_stall
);

	dcache_pkg::cache_state_t state;
	dcache_pkg::addr_t addr_buf;
	dcache_pkg::word_t wdata_buf;
	dcache_pkg::mask_t mask_buf;
	logic write_buf;
	logic in_cache;
	logic in_update;
	logic cur_write;
	logic request;
	dcache_pkg::word_t refill_word;
	dcache_pkg::mem_idx_t victim_idx;
	dcache_pkg::mem_idx_t req_idx;
	dcache_pkg::word_t mem [dcache_pkg::MEM_WORDS];

	assign in_cache = (state == dcache_pkg::IN_CACHE);
	assign in_update = (state == dcache_pkg::UPDATE_CACHE);

	// Live inputs while idle, the buffered request during a miss
	assign cur_addr = in_cache ? addr : addr_buf;
	assign cur_wdata = in_cache ? write_data : wdata_buf;
	assign cur_mask = in_cache ? sign_mask : mask_buf;
	assign cur_write = in_cache ? memwrite : write_buf;

	assign request = in_cache & (memread | memwrite);
	assign source_word = in_update ? refill_word : sel_word;

	assign access = (request & hit) | in_update;
	assign line_write = (request & memwrite & hit) | in_update;
	assign line_wdata = cur_write ? merged_word : source_word;

	assign victim_idx = sel_tag[dcache_pkg::MEM_IDX_W-1:0];
	assign req_idx = cur_addr[dcache_pkg::MEM_IDX_W+1:2];

	// Request buffer follows the inputs until a miss freezes it
	always_ff @(posedge clk) begin
		if (in_cache) begin
			addr_buf <= addr;
			wdata_buf <= write_data;
			mask_buf <= sign_mask;
			write_buf <= memwrite;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= dcache_pkg::IN_CACHE;
			clk_stall <= 1'b0;
			read_data <= '0;
		end else begin
			case (state)
				dcache_pkg::IN_CACHE: begin
					if (request) begin
						if (!hit) begin
							state <= dcache_pkg::ACCESS_MEMORY;
							clk_stall <= 1'b1;
						end else if (!cur_write) begin
							read_data <= load_word;
						end
					end
				end
				dcache_pkg::ACCESS_MEMORY: begin
					state <= dcache_pkg::UPDATE_CACHE;
				end
				dcache_pkg::UPDATE_CACHE: begin
					// Refilled word is on source_word and the victim line loads it now
					if (!cur_write)
						read_data <= load_word;
					clk_stall <= 1'b0;
					state <= dcache_pkg::IN_CACHE;
				end
				default: begin
					state <= dcache_pkg::IN_CACHE;
				end
			endcase
		end
	end

	// Write back the victim and fetch the requested word in the same cycle
	always_ff @(posedge clk) begin
		if (state == dcache_pkg::ACCESS_MEMORY) begin
			if (sel_valid)
				mem[victim_idx] <= sel_word;
			refill_word <= mem[req_idx];
		end
	end

	// LED register, only the low byte of the store is kept
	always_ff @(posedge clk) begin
		if (!rst_n)
			led <= '0;
		else if (in_cache && memwrite && (addr == dcache_pkg::LED_ADDR))
			led <= write_data[7:0];
	end

endmodule

// File: design/data_mem_cached.sv
// Cached data memory
`timescale 1ns/1ps

module data_mem_cached (
	input  logic               clk,
	input  logic               rst_n,
	input  dcache_pkg::addr_t  addr,
	input  dcache_pkg::word_t  write_data,
	input  logic               memwrite,
	input  logic               memread,
	input  dcache_pkg::mask_t  sign_mask,
	output dcache_pkg::word_t  read_data,
	output logic [7:0]         led,
	output logic               clk_stall
);

	dcache_pkg::addr_t cur_addr;
	dcache_pkg::word_t cur_wdata;
	dcache_pkg::mask_t cur_mask;
	dcache_pkg::word_t source_word;
	dcache_pkg::word_t merged_word;
	dcache_pkg::word_t load_word;
	dcache_pkg::word_t sel_word;
	dcache_pkg::tag_t sel_tag;
	dcache_pkg::word_t line_wdata;
	logic sel_valid;
	logic hit;
	logic access;
	logic line_write;

	miss_control i_miss_control (
		.clk         (clk),
		.rst_n       (rst_n),
		.addr        (addr),
		.write_data  (write_data),
		.memwrite    (memwrite),
		.memread     (memread),
		.sign_mask   (sign_mask),
		.hit         (hit),
		.sel_word    (sel_word),
		.sel_tag     (sel_tag),
		.sel_valid   (sel_valid),
		.load_word   (load_word),
		.merged_word (merged_word),
		.cur_addr    (cur_addr),
		.cur_wdata   (cur_wdata),
		.cur_mask    (cur_mask),
		.source_word (source_word),
		.access      (access),
		.line_write  (line_write),
		.line_wdata  (line_wdata),
		.read_data   (read_data),
		.led         (led),
		.clk_stall   (clk_stall)
	);

	line_array i_line_array (
		.clk        (clk),
		.rst_n      (rst_n),
		.cur_addr   (cur_addr),
		.line_wdata (line_wdata),
		.line_write (line_write),
		.access     (access),
		.hit        (hit),
		.sel_word   (sel_word),
		.sel_tag    (sel_tag),
		.sel_valid  (sel_valid)
	);

	// Both datapath blocks work on the same source word and byte offset
	store_merge i_store_merge (
		.source_word (source_word),
		.store_data  (cur_wdata),
		.offset      (cur_addr[1:0]),
		.mask        (cur_mask),
		.merged_word (merged_word)
	);

	load_align i_load_align (
		.source_word (source_word),
		.offset      (cur_addr[1:0]),
		.mask        (cur_mask),
		.load_word   (load_word)
	);

endmodule

// File: verification/cache_chk.sv
// Miss controller assertions
`timescale 1ns/1ps

module cache_chk (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      clk_stall,
	input logic                      line_write,
	input dcache_pkg::cache_state_t  state
);

	int assert_fails;

	// A miss holds the stall for exactly two edges
	stall_length: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(clk_stall) |=> clk_stall ##1 !clk_stall)
	else begin
		$error("clk_stall did not fall two edges after it rose");
		assert_fails++;
	end

	stall_after_reset: assert property (@(posedge clk) !rst_n |=> !clk_stall)
	else begin
		$error("clk_stall is high right after reset");
		assert_fails++;
	end

	// The line is written only once the refill word has arrived
	no_write_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		(state == dcache_pkg::ACCESS_MEMORY) |-> !line_write)
	else begin
		$error("line_write is high while the state is ACCESS_MEMORY");
		assert_fails++;
	end

endmodule

bind miss_control cache_chk i_cache_chk (
	.clk        (clk),
	.rst_n      (rst_n),
	.clk_stall  (clk_stall),
	.line_write (line_write),
	.state      (state)
);

// File: verification/cache_monitor.sv
// Cache reference model and checker
`timescale 1ns/1ps

module cache_monitor (
	input  logic               clk,
	input  logic               rst_n,
	input  dcache_pkg::addr_t  addr,
	input  dcache_pkg::word_t  write_data,
	input  logic               memwrite,
	input  logic               memread,
	input  dcache_pkg::mask_t  sign_mask,
	input  dcache_pkg::word_t  exp_data,
	input  dcache_pkg::word_t  read_data,
	input  logic [7:0]         led,
	input  logic               clk_stall,
	output int                 error_count,
	output int                 check_count
);

	// Architectural memory indexed by word address, without the cache
	dcache_pkg::word_t model_mem [1 << dcache_pkg::TAG_W];
	dcache_pkg::tag_t model_tag [dcache_pkg::CACHE_LINES];
	logic model_valid [dcache_pkg::CACHE_LINES];
	int model_age [dcache_pkg::CACHE_LINES];
	logic [7:0] model_led;
	int stall_edges;
	logic load_pending;
	logic was_reset;
	dcache_pkg::word_t model_value;
	dcache_pkg::word_t file_value;

	function automatic dcache_pkg::word_t merge_store(dcache_pkg::word_t old_word,
			dcache_pkg::word_t data, dcache_pkg::byte_off_t offset, dcache_pkg::mask_t mask);
		int shift;
		dcache_pkg::word_t lanes;
		if (mask[dcache_pkg::MASK_WORD]) begin
			shift = 0;
			lanes = 32'hffff_ffff;
		end else if (mask[dcache_pkg::MASK_HALF]) begin
			shift = 16 * offset[1];
			lanes = 32'h0000_ffff << shift;
		end else begin
			shift = 8 * offset;
			lanes = 32'h0000_00ff << shift;
		end
		return (old_word & ~lanes) | ((data << shift) & lanes);
	endfunction

	function automatic dcache_pkg::word_t extract_load(dcache_pkg::word_t word,
			dcache_pkg::byte_off_t offset, dcache_pkg::mask_t mask);
		dcache_pkg::word_t lane;
		logic signed_load;
		signed_load = mask[dcache_pkg::MASK_SIGNED];
		if (mask[dcache_pkg::MASK_WORD])
			return word;
		if (mask[dcache_pkg::MASK_HALF]) begin
			lane = word >> (16 * offset[1]);
			return {{16{signed_load & lane[15]}}, lane[15:0]};
		end
		lane = word >> (8 * offset);
		return {{24{signed_load & lane[7]}}, lane[7:0]};
	endfunction

	task automatic compare(input string what, input dcache_pkg::word_t got,
			input dcache_pkg::word_t want);
		check_count++;
		if (got !== want) begin
			error_count++;
			$display("error at %0d ns: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	// Looks up the request, applies the age rules and updates memory and led
	task automatic model_request();
		int way;
		int old_age;
		logic hit;
		dcache_pkg::tag_t tag;
		tag = addr[dcache_pkg::ADDR_W-1:2];
		way = -1;
		for (int i = 0; i < dcache_pkg::CACHE_LINES; i++)
			if (model_valid[i] && model_tag[i] == tag)
				way = i;
		hit = (way >= 0);
		for (int i = 0; i < dcache_pkg::CACHE_LINES; i++)
			if (!hit && model_age[i] == 0)
				way = i;
		old_age = model_age[way];
		for (int i = 0; i < dcache_pkg::CACHE_LINES; i++) begin
			if (i == way)
				model_age[i] = dcache_pkg::CACHE_LINES - 1;
			else if (model_age[i] > old_age)
				model_age[i]--;
		end
		model_tag[way] = tag;
		model_valid[way] = 1'b1;
		if (memwrite) begin
			model_mem[tag] = merge_store(model_mem[tag], write_data, addr[1:0], sign_mask);
			if (addr == dcache_pkg::LED_ADDR)
				model_led = write_data[7:0];
		end else begin
			model_value = extract_load(model_mem[tag], addr[1:0], sign_mask);
			file_value = exp_data;
		end
		load_pending = !memwrite;
		stall_edges = hit ? 1 : 3;
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < dcache_pkg::CACHE_LINES; i++) begin
				model_valid[i] = 1'b0;
				model_age[i] = i;
			end
			model_led = 8'h00;
			stall_edges = 0;
			load_pending = 1'b0;
			was_reset = 1'b1;
		end else begin
			if (was_reset) begin
				compare("read_data after reset", read_data, '0);
				compare("clk_stall after reset", dcache_pkg::word_t'(clk_stall), '0);
				was_reset = 1'b0;
			end
			compare("led", dcache_pkg::word_t'(led), dcache_pkg::word_t'(model_led));
			// A hit never stalls and a miss stays high for two edges
			if (stall_edges > 0) begin
				stall_edges--;
				compare("clk_stall", dcache_pkg::word_t'(clk_stall),
					dcache_pkg::word_t'(stall_edges != 0));
				if (stall_edges == 0 && load_pending) begin
					compare("read_data against model", read_data, model_value);
					compare("read_data against file", read_data, file_value);
					load_pending = 1'b0;
				end
			end else begin
				compare("clk_stall while idle", dcache_pkg::word_t'(clk_stall), '0);
			end
			if (stall_edges == 0 && !clk_stall && (memread || memwrite))
				model_request();
		end
	end

endmodule

// File: verification/tb_top.sv
// Data memory cache testbench
`timescale 1ns/1ps

module tb_top;

	logic clk;
	logic rst_n;
	dcache_pkg::addr_t addr;
	dcache_pkg::word_t write_data;
	logic memwrite;
	logic memread;
	dcache_pkg::mask_t sign_mask;
	dcache_pkg::word_t exp_data;
	dcache_pkg::word_t read_data;
	logic [7:0] led;
	logic clk_stall;
	int error_count;
	int check_count;

	data_mem_cached i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr       (addr),
		.write_data (write_data),
		.memwrite   (memwrite),
		.memread    (memread),
		.sign_mask  (sign_mask),
		.read_data  (read_data),
		.led        (led),
		.clk_stall  (clk_stall)
	);

	cache_monitor i_monitor (
		.clk         (clk),
		.rst_n       (rst_n),
		.addr        (addr),
		.write_data  (write_data),
		.memwrite    (memwrite),
		.memread     (memread),
		.sign_mask   (sign_mask),
		.exp_data    (exp_data),
		.read_data   (read_data),
		.led         (led),
		.clk_stall   (clk_stall),
		.error_count (error_count),
		.check_count (check_count)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic apply_request(input logic [63:0] op, input dcache_pkg::addr_t a,
			input dcache_pkg::mask_t m, input dcache_pkg::word_t wd,
			input dcache_pkg::word_t ex);
		addr = a;
		write_data = wd;
		sign_mask = m;
		exp_data = ex;
		memread = (op == "load");
		memwrite = (op == "store");
	endtask

	// One edge takes the request, a miss then holds the stall for two more
	task automatic wait_stall_low(output bit timed_out);
		int cycles;
		cycles = 0;
		@(posedge clk);
		#1;
		while (clk_stall !== 1'b0 && cycles < 20) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		timed_out = (clk_stall !== 1'b0);
	endtask

	task automatic finish_run(input bit aborted);
		int chk_fails;
		chk_fails = i_dut.i_miss_control.i_cache_chk.assert_fails;
		$display("checks %0d, value errors %0d, assertion failures %0d, aborted %0d",
			check_count, error_count, chk_fails, aborted);
		if (error_count == 0 && chk_fails == 0 && !aborted)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	initial begin
		logic [63:0] op;
		logic [8*80-1:0] rest;
		dcache_pkg::addr_t a;
		dcache_pkg::mask_t m;
		dcache_pkg::word_t wd;
		dcache_pkg::word_t ex;
		int fd;
		int code;
		bit stalled;
		bit run_failed;
		bit done;
		rst_n = 1'b0;
		apply_request("idle", '0, '0, '0, '0);
		run_failed = 1'b0;
		done = 1'b0;
		fd = $fopen("verification/dcache_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file verification/dcache_input.txt");
			run_failed = 1'b1;
		end
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		while (fd != 0 && !run_failed && !done) begin
			code = $fscanf(fd, "%s", op);
			if (code != 1) begin
				done = 1'b1;
			end else if (op == "#") begin
				code = $fgets(rest, fd);
			end else begin
				code = $fscanf(fd, "%h %h %h %h", a, m, wd, ex);
				if (code != 4) begin
					$display("malformed line in the stimulus file");
					run_failed = 1'b1;
				end else begin
					apply_request(op, a, m, wd, ex);
					wait_stall_low(stalled);
					if (stalled) begin
						$display("clk_stall did not fall within 20 cycles of a request");
						run_failed = 1'b1;
					end
				end
			end
		end
		// Let the monitor see the last response
		apply_request("idle", '0, '0, '0, '0);
		repeat (3) @(posedge clk);
		finish_run(run_failed);
	end

endmodule

// File: verification/dcache_input.txt
# op addr mask wdata expected
# mask bits 3 signed, 2 word, 1 half or word, 0 access
store 0100 7 12345678 00000000
load  0100 7 00000000 12345678
load  0100 7 00000000 12345678
store 0104 7 a5a5a5a5 00000000
store 0104 1 000000ff 00000000
store 0105 1 00000011 00000000
store 0106 1 00000022 00000000
store 0107 1 00000033 00000000
load  0104 7 00000000 332211ff
store 0108 7 00000000 00000000
store 0108 3 0000beef 00000000
store 010a 3 0000cafe 00000000
load  0108 7 00000000 cafebeef
load  0104 1 00000000 000000ff
load  0104 9 00000000 ffffffff
load  0105 9 00000000 00000011
load  0107 1 00000000 00000033
load  0106 9 00000000 00000022
store 0106 1 00000080 00000000
load  0106 9 00000000 ffffff80
load  0106 1 00000000 00000080
load  0104 7 00000000 338011ff
load  0108 3 00000000 0000beef
load  0108 b 00000000 ffffbeef
load  010a b 00000000 ffffcafe
load  010a 3 00000000 0000cafe
store 2000 7 000001c3 00000000
idle  0000 0 00000000 00000000
store 010c 7 0badf00d 00000000
load  2000 7 00000000 000001c3
store 0200 7 11112222 00000000
store 0204 7 33334444 00000000
store 0208 7 55556666 00000000
store 020c 7 77778888 00000000
store 0210 7 9999aaaa 00000000
load  0100 7 00000000 12345678
load  0104 7 00000000 338011ff
load  0108 7 00000000 cafebeef
load  010c 7 00000000 0badf00d
load  0200 7 00000000 11112222
load  0210 7 00000000 9999aaaa
load  2000 1 00000000 000000c3
store 2000 7 0000005a 00000000
store 2001 1 000000ff 00000000
load  2000 7 00000000 0000ff5a
load  2001 9 00000000 ffffffff
store 0204 3 00008001 00000000
load  0204 b 00000000 ffff8001
load  0206 3 00000000 00003333
idle  0000 0 00000000 00000000

// File: filelist.f
design/dcache_pkg.sv
design/cache_line.sv
design/line_array.sv
design/store_merge.sv
design/load_align.sv
design/miss_control.sv
design/data_mem_cached.sv
verification/cache_chk.sv
verification/cache_monitor.sv
verification/tb_top.sv
